/* sim.f */
verilog/irq_pkg.sv
verilog/irq_config_table.sv
verilog/ext_irq_latch.sv
verilog/irq_dispatcher.sv
verilog/interrupt_manager_top.sv
dv/tb_interrupt_manager.sv

/* run.sh */
#!/bin/sh
# Build and run the interrupt manager testbench with Verilator
cd "$(dirname "$0")" || exit 1

rm -rf obj_dir build.log sim.log

verilator --binary --timing -f sim.f --top-module tb_interrupt_manager \
	-o tb_interrupt_manager > build.log 2>&1 \
	|| { cat build.log; echo "Verilator build failed"; exit 1; }

./obj_dir/tb_interrupt_manager > sim.log 2>&1
cat sim.log

# The run passes only if the log holds the pass line
grep -qx '\*\*\* PASSED \*\*\*' sim.log && exit 0 || exit 1

/* dv/tb_interrupt_manager.sv */
module tb_interrupt_manager;

	timeunit 1ns;
	timeprecision 1ps;

	import irq_pkg::*;

	localparam int CLK_PERIOD    = 40;
	localparam int RESET_CYCLES  = 5;
	// Rough length of each test in cycles, in run order
	localparam int TEST_CYCLES   = 4 + 12 + 8 + 24 + 14 + 20;
	localparam int MARGIN_CYCLES = 50;
	localparam logic [31:0] SEED = 32'h9424_2869;

	logic       iCLOCK;
	logic       inRESET;
	logic       ict_wr_en;
	ict_write_t ict_wr;
	fault_req_t fault;
	ext_req_t   ext;
	logic       exc_lock;
	logic       exc_ack;
	logic       ext_ack;
	exc_req_t   exc;

	logic [31:0] lcg_state;
	int          error_count;
	int          tests_passed;
	int          tests_failed;

	// Table contents as written so far
	bit model_valid [ICT_ENTRIES];
	bit model_mask  [ICT_ENTRIES];

	interrupt_manager_top dut_i (
		.iCLOCK    (iCLOCK),
		.inRESET   (inRESET),
		.ict_wr_en (ict_wr_en),
		.ict_wr    (ict_wr),
		.fault     (fault),
		.ext       (ext),
		.ext_ack   (ext_ack),
		.exc_lock  (exc_lock),
		.exc_ack   (exc_ack),
		.exc       (exc)
	);

	initial begin
		iCLOCK = 1'b0;
		forever #(CLK_PERIOD / 2) iCLOCK = ~iCLOCK;
	end

	initial begin
		#((RESET_CYCLES + TEST_CYCLES + MARGIN_CYCLES) * CLK_PERIOD);
		$display("Timeout: the tests did not finish in the expected time");
		$display("*** FAILED ***");
		$finish;
	end

	function automatic logic [31:0] next_rand();
		lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
		return lcg_state;
	endfunction

	// Not valid admits everything, valid admits only with mask set
	function automatic bit predict_admit(input logic [EXT_NUM_W-1:0] entry);
		return !model_valid[entry] || model_mask[entry];
	endfunction

	task automatic expect_eq(input string name, input logic [63:0] got, input logic [63:0] exp);
		if (got !== exp) begin
			$display("** Error at %0t ns: %s expected %0h, got %0h", $time, name, exp, got);
			error_count++;
		end
	endtask

	task automatic report_test(input string name, input int errors_before);
		if (error_count == errors_before) begin
			tests_passed++;
			$display("%s: ok", name);
		end else begin
			tests_failed++;
			$display("%s: %0d error(s)", name, error_count - errors_before);
		end
	endtask

	task automatic write_entry(input logic [EXT_NUM_W-1:0] entry, input logic mask,
			input logic valid);
		ict_wr_en    = 1'b1;
		ict_wr.entry = entry;
		ict_wr.mask  = mask;
		ict_wr.valid = valid;
		@(negedge iCLOCK);
		ict_wr_en = 1'b0;
		model_valid[entry] = valid;
		model_mask[entry]  = mask;
	endtask

	// One cycle of exc_ack, then the IDLE view is checked
	task automatic ack_request(input logic active_after);
		exc_ack = 1'b1;
		@(negedge iCLOCK);
		expect_eq("exc.active", 64'(exc.active), 64'(active_after));
		exc_ack = 1'b0;
	endtask

	task automatic wait_ext_ack(input int max_cycles);
		int cycles;
		cycles = 0;
		while (ext_ack !== 1'b1 && cycles < max_cycles) begin
			@(negedge iCLOCK);
			cycles++;
		end
		if (ext_ack !== 1'b1) begin
			$display("Error at %0t ns: no ext_ack pulse within %0d cycles", $time, max_cycles);
			error_count++;
		end
	endtask

	// External line is up; wait for its dispatch and retire it
	task automatic collect_ext(input logic [EXT_NUM_W-1:0] num);
		wait_ext_ack(4);
		expect_eq("exc.active", 64'(exc.active), 64'd1);
		expect_eq("exc.num", 64'(exc.num), 64'({1'b0, num}));
		expect_eq("exc.fi0r", 64'(exc.fi0r), 64'd0);
		ext.active = 1'b0;
		@(negedge iCLOCK);
		expect_eq("ext_ack", 64'(ext_ack), 64'd0);
		ack_request(1'b0);
	endtask

	task automatic run_ext(input logic [EXT_NUM_W-1:0] num);
		ext.active = 1'b1;
		ext.num    = num;
		if (predict_admit(num)) begin
			collect_ext(num);
		end else begin
			repeat (6) begin
				@(negedge iCLOCK);
				expect_eq("ext_ack", 64'(ext_ack), 64'd0);
				expect_eq("exc.active", 64'(exc.active), 64'd0);
			end
			ext.active = 1'b0;
			@(negedge iCLOCK);
		end
	endtask

	task automatic reset_quiet();
		int errs;
		errs = error_count;
		repeat (3) begin
			@(negedge iCLOCK);
			expect_eq("exc.active", 64'(exc.active), 64'd0);
			expect_eq("ext_ack", 64'(ext_ack), 64'd0);
		end
		report_test("reset_quiet", errs);
	endtask

	task automatic fault_dispatch();
		int          errs;
		int          hold;
		logic [31:0] r;
		logic [31:0] info;
		logic [6:0]  num;
		errs = error_count;
		r    = next_rand();
		num  = r[22:16];
		hold = 2 + int'(r[2:0]);
		info = next_rand();
		fault.active = 1'b1;
		fault.num    = num;
		fault.fi0r   = info;
		@(negedge iCLOCK);
		expect_eq("exc.active", 64'(exc.active), 64'd1);
		expect_eq("exc.num", 64'(exc.num), 64'(num));
		expect_eq("exc.fi0r", 64'(exc.fi0r), 64'(info));
		expect_eq("ext_ack", 64'(ext_ack), 64'd0);
		fault.active = 1'b0;
		// Held until the exception manager answers
		repeat (hold) begin
			@(negedge iCLOCK);
			expect_eq("exc.active", 64'(exc.active), 64'd1);
			expect_eq("exc.num", 64'(exc.num), 64'(num));
			expect_eq("ext_ack", 64'(ext_ack), 64'd0);
		end
		ack_request(1'b0);
		report_test("fault_dispatch", errs);
	endtask

	task automatic ext_dispatch();
		int          errs;
		logic [31:0] r;
		errs = error_count;
		r    = next_rand();
		run_ext(r[13:8]);
		report_test("ext_dispatch", errs);
	endtask

	task automatic mask_gating();
		int                   errs;
		logic [31:0]          r;
		logic [EXT_NUM_W-1:0] entry;
		errs  = error_count;
		r     = next_rand();
		entry = r[19:14];
		write_entry(entry, 1'b0, 1'b1);
		run_ext(entry);
		write_entry(entry, 1'b1, 1'b1);
		run_ext(entry);
		report_test("mask_gating", errs);
	endtask

	task automatic fault_before_ext();
		int                   errs;
		logic [31:0]          r;
		logic [31:0]          info;
		logic [6:0]           num;
		logic [EXT_NUM_W-1:0] en;
		errs = error_count;
		r    = next_rand();
		num  = r[30:24];
		en   = r[11:6];
		info = next_rand();
		fault.active = 1'b1;
		fault.num    = num;
		fault.fi0r   = info;
		ext.active   = 1'b1;
		ext.num      = en;
		@(negedge iCLOCK);
		expect_eq("exc.num", 64'(exc.num), 64'(num));
		expect_eq("exc.fi0r", 64'(exc.fi0r), 64'(info));
		expect_eq("ext_ack", 64'(ext_ack), 64'd0);
		fault.active = 1'b0;
		@(negedge iCLOCK);
		expect_eq("exc.num", 64'(exc.num), 64'(num));
		expect_eq("ext_ack", 64'(ext_ack), 64'd0);
		// Latched external request is still pending
		ack_request(1'b1);
		collect_ext(en);
		report_test("fault_before_ext", errs);
	endtask

	task automatic lock_stall();
		int                   errs;
		int                   lock_cycles;
		logic [31:0]          r;
		logic [31:0]          info;
		logic [6:0]           num;
		logic [EXT_NUM_W-1:0] en;
		errs        = error_count;
		r           = next_rand();
		lock_cycles = 2 + int'(r[2:0]);
		num         = r[15:9];
		en          = r[27:22];
		info        = next_rand();
		exc_lock   = 1'b1;
		ext.active = 1'b1;
		ext.num    = en;
		// Latch fills and shows as active, but nothing is taken
		repeat (lock_cycles) begin
			@(negedge iCLOCK);
			expect_eq("ext_ack", 64'(ext_ack), 64'd0);
			expect_eq("exc.active", 64'(exc.active), 64'd1);
			expect_eq("exc.num", 64'(exc.num), 64'({1'b0, en}));
		end
		fault.active = 1'b1;
		fault.num    = num;
		fault.fi0r   = info;
		@(negedge iCLOCK);
		expect_eq("ext_ack", 64'(ext_ack), 64'd0);
		expect_eq("exc.num", 64'(exc.num), 64'({1'b0, en}));
		exc_lock = 1'b0;
		@(negedge iCLOCK);
		expect_eq("exc.active", 64'(exc.active), 64'd1);
		expect_eq("exc.num", 64'(exc.num), 64'(num));
		expect_eq("exc.fi0r", 64'(exc.fi0r), 64'(info));
		expect_eq("ext_ack", 64'(ext_ack), 64'd0);
		fault.active = 1'b0;
		// Latched external request follows the fault
		ack_request(1'b1);
		collect_ext(en);
		report_test("lock_stall", errs);
	endtask

	initial begin
		inRESET      = 1'b0;
		ict_wr_en    = 1'b0;
		ict_wr       = '0;
		fault        = '0;
		ext          = '0;
		exc_lock     = 1'b0;
		exc_ack      = 1'b0;
		lcg_state    = SEED;
		error_count  = 0;
		tests_passed = 0;
		tests_failed = 0;
		repeat (RESET_CYCLES) @(posedge iCLOCK);
		@(negedge iCLOCK);
		inRESET = 1'b1;

		reset_quiet();
		fault_dispatch();
		ext_dispatch();
		mask_gating();
		fault_before_ext();
		lock_stall();

		$display("Tests passed: %0d, failed: %0d, errors: %0d", tests_passed, tests_failed,
			error_count);
		if (tests_failed == 0 && error_count == 0) begin
			$display("*** PASSED ***");
		end else begin
			$display("*** FAILED ***");
		end
		$finish;
	end

endmodule

/* verilog/interrupt_manager_top.sv */
module interrupt_manager_top (
	input  logic                iCLOCK,
	input  logic                inRESET,
	// Table configuration
	input  logic                ict_wr_en,
	input  irq_pkg::ict_write_t ict_wr,
	// Execution unit
	input  irq_pkg::fault_req_t fault,
	// External interrupt source
	input  irq_pkg::ext_req_t   ext,
	output logic                ext_ack,
	// Exception manager
	input  logic                exc_lock,
	input  logic                exc_ack,
	output irq_pkg::exc_req_t   exc
);

	import irq_pkg::*;

	// Table lookup result for the live line
	logic admit;

	// Latched external request and its release
	ext_req_t held;
	logic     ext_take;

	irq_config_table table_i (
		.iCLOCK    (iCLOCK),
		.inRESET   (inRESET),
		.ict_wr_en (ict_wr_en),
		.ict_wr    (ict_wr),
		.ext_num   (ext.num),
		.admit     (admit)
	);

	ext_irq_latch latch_i (
		.iCLOCK   (iCLOCK),
		.inRESET  (inRESET),
		.ext      (ext),
		.admit    (admit),
		.ext_take (ext_take),
		.held     (held)
	);

	// Fault path and arbitration
	irq_dispatcher dispatch_i (
		.iCLOCK   (iCLOCK),
		.inRESET  (inRESET),
		.fault    (fault),
		.ext      (ext),
		.admit    (admit),
		.held     (held),
		.exc_lock (exc_lock),
		.exc_ack  (exc_ack),
		.ext_take (ext_take),
		.ext_ack  (ext_ack),
		.exc      (exc)
	);

endmodule

/* verilog/irq_dispatcher.sv */
module irq_dispatcher (
	input  logic                iCLOCK,
	input  logic                inRESET,
	input  irq_pkg::fault_req_t fault,
	input  irq_pkg::ext_req_t   ext,
	input  logic                admit,
	input  irq_pkg::ext_req_t   held,
	input  logic                exc_lock,
	input  logic                exc_ack,
	output logic                ext_take,
	output logic                ext_ack,
	output irq_pkg::exc_req_t   exc
);

	import irq_pkg::*;

	// Padding that widens an external number to a dispatched number
	localparam int PAD_W = IRQ_NUM_W - EXT_NUM_W;

	dsp_state_t state_q;

	// Captured request, shown while in WAIT
	logic [IRQ_NUM_W-1:0] cap_num_q;
	logic [FI0R_W-1:0]    cap_fi0r_q;
	logic                 ext_ack_q;

	// Lock-qualified request views
	logic idle_free;
	logic fault_valid;
	logic ext_valid;

	// External numbers in the dispatched width
	logic [IRQ_NUM_W-1:0] held_num;
	logic [IRQ_NUM_W-1:0] live_num;

	assign idle_free   = (state_q == DSP_IDLE) && !exc_lock;
	assign fault_valid = fault.active && !exc_lock;
	assign ext_valid   = ext.active && admit && !exc_lock;

	assign held_num = {{PAD_W{1'b0}}, held.num};
	assign live_num = {{PAD_W{1'b0}}, ext.num};

	// Faults win, so the latch is only emptied with no fault pending
	assign ext_take = idle_free && !fault.active && held.active;

	always_ff @(posedge iCLOCK or negedge inRESET) begin
		if (!inRESET) begin
			state_q    <= DSP_IDLE;
			cap_num_q  <= '0;
			cap_fi0r_q <= '0;
			ext_ack_q  <= 1'b0;
		end else begin
			case (state_q)
				DSP_IDLE: begin
					if (idle_free && fault.active) begin
						state_q    <= DSP_WAIT;
						cap_num_q  <= fault.num;
						cap_fi0r_q <= fault.fi0r;
					end else if (ext_take) begin
						state_q    <= DSP_WAIT;
						cap_num_q  <= held_num;
						cap_fi0r_q <= '0;
						ext_ack_q  <= 1'b1;
					end
				end
				DSP_WAIT: begin
					// Acknowledge toward the source lasts one cycle
					ext_ack_q <= 1'b0;
					if (exc_ack) begin
						state_q <= DSP_IDLE;
					end
				end
			endcase
		end
	end

	assign ext_ack = ext_ack_q;

	// WAIT shows the held request until the exception manager takes it;
	// IDLE gives an early look at what would be captured next
	always_comb begin
		if (state_q == DSP_WAIT) begin
			exc.active = !exc_ack;
			exc.num    = cap_num_q;
			exc.fi0r   = cap_fi0r_q;
		end else begin
			exc.active = fault_valid || ext_valid || held.active;
			if (fault_valid) begin
				exc.num  = fault.num;
				exc.fi0r = fault.fi0r;
			end else begin
				exc.num  = live_num;
				exc.fi0r = '0;
			end
		end
	end

endmodule

/* verilog/ext_irq_latch.sv */
module ext_irq_latch (
	input  logic              iCLOCK,
	input  logic              inRESET,
	input  irq_pkg::ext_req_t ext,
	input  logic              admit,
	input  logic              ext_take,
	output irq_pkg::ext_req_t held
);

	import irq_pkg::*;

	ext_req_t held_q;

	// Fill condition, only while empty
	logic capture;

	assign capture = !held_q.active && ext.active && admit;

	always_ff @(posedge iCLOCK or negedge inRESET) begin
		if (!inRESET) begin
			held_q.active <= 1'b0;
			held_q.num    <= '0;
		end else begin
			if (capture) begin
				held_q.active <= 1'b1;
				held_q.num    <= ext.num;
			end else if (ext_take) begin
				// Number is left as is, only the flag drops
				held_q.active <= 1'b0;
			end
		end
	end

	// While full, further requests are ignored
	// and the source keeps its line up
	assign held = held_q;

endmodule

/* verilog/irq_config_table.sv */
module irq_config_table (
	input  logic                         iCLOCK,
	input  logic                         inRESET,
	input  logic                         ict_wr_en,
	input  irq_pkg::ict_write_t          ict_wr,
	input  logic [irq_pkg::EXT_NUM_W-1:0] ext_num,
	output logic                         admit
);

	import irq_pkg::*;

	// One valid and one mask bit per entry
	logic [ICT_ENTRIES-1:0] valid_q;
	logic [ICT_ENTRIES-1:0] mask_q;

	// Looked-up bits for the live external number
	logic entry_valid;
	logic entry_mask;

	always_ff @(posedge iCLOCK or negedge inRESET) begin
		if (!inRESET) begin
			valid_q <= '0;
			mask_q  <= '0;
		end else begin
			if (ict_wr_en) begin
				valid_q[ict_wr.entry] <= ict_wr.valid;
				mask_q[ict_wr.entry]  <= ict_wr.mask;
			end
		end
	end

	assign entry_valid = valid_q[ext_num];
	assign entry_mask  = mask_q[ext_num];

	// Unconfigured entries let everything through;
	// a configured entry passes only with its mask bit set
	always_comb begin
		if (!entry_valid) begin
			admit = 1'b1;
		end else begin
			admit = entry_mask;
		end
	end

endmodule

/* verilog/irq_pkg.sv */
package irq_pkg;

	// Interrupt configuration table size
	localparam int ICT_ENTRIES = 64;

	// External line number, also the table index
	localparam int EXT_NUM_W = 6;

	// Number handed to the exception manager
	// Top bit is 0 for external interrupts
	localparam int IRQ_NUM_W = 7;

	// Fault information register value
	localparam int FI0R_W = 32;

	// One write into the configuration table
	typedef struct packed {
		logic [EXT_NUM_W-1:0] entry;
		logic                 mask;
		logic                 valid;
	} ict_write_t;

	// Synchronous fault from the execution unit
	typedef struct packed {
		logic                 active;
		logic [IRQ_NUM_W-1:0] num;
		logic [FI0R_W-1:0]    fi0r;
	} fault_req_t;

	// External interrupt line and its number
	typedef struct packed {
		logic                 active;
		logic [EXT_NUM_W-1:0] num;
	} ext_req_t;

	// Request offered to the exception manager
	typedef struct packed {
		logic                 active;
		logic [IRQ_NUM_W-1:0] num;
		logic [FI0R_W-1:0]    fi0r;
	} exc_req_t;

	// Dispatcher FSM
	typedef enum logic {
		DSP_IDLE = 1'b0,
		DSP_WAIT = 1'b1
	} dsp_state_t;

endpackage
